/* all.f */
verilog/fetch_pkg.sv
verilog/fetch_hazard_ctrl.sv
verilog/fetch_pc_gen.sv
verilog/fetch_wb_master.sv
verilog/branch_target_buffer.sv
verilog/fetch_ex_latch.sv
verilog/fetch_unit_top.sv
test/fetch_tb.sv

/* test/fetch_tb.sv */
/*
 * Table-driven testbench for the fetch front end. A Wishbone slave model with
 * LFSR wait states answers from a hashed memory. Each table row drives
 * trap, redirect, BTB update and stall, then checks the next valid entry.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam addr_t RESET_PC    = 32'h8000_0000;
    localparam int    BTB_ENTRIES = 16;
    localparam bit    BUS_LITTLE  = 1'b1;
    localparam addr_t ERR_BASE    = RESET_PC + 32'h800;   // Four words answer with ERR

    typedef struct packed {
        logic [1:0] lead;      // Idle cycles before driving so a fetch is in flight
        redirect_t  trap;
        redirect_t  redir;
        btb_upd_t   upd;
        logic [3:0] stall_n;   // Cycles of stall from the drive edge
        addr_t      pc;        // Expected entry
        logic       mal;
        logic       fault;
        logic       pred;
        addr_t      tgt;       // Only checked when pred is set
    } row_t;

    logic      CLK;
    logic      nRST;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    redirect_t trap;
    redirect_t redirect;
    btb_upd_t  btb_update;
    logic      stall;
    fetch_ex_t fetch_ex;

    word_t       mem [1024];   // Covers RESET_PC up to RESET_PC + 4 KiB
    row_t        rows [$];
    string       test_name;
    int          errors = 0;
    logic [31:0] lfsr;
    logic [1:0]  waits;
    logic        in_cycle = 1'b0;

    fetch_unit_top #(
        .RESET_PC    (RESET_PC),
        .BTB_ENTRIES (BTB_ENTRIES),
        .BUS_LITTLE  (BUS_LITTLE)
    ) u_fetch_unit_top (
        .CLK        (CLK),
        .nRST       (nRST),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .trap       (trap),
        .redirect   (redirect),
        .btb_update (btb_update),
        .stall      (stall),
        .fetch_ex   (fetch_ex)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;   // 8 ns period
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // Galois step for x^32+x^22+x^2+x+1
    endfunction

    function automatic word_t addr_hash(input addr_t a);
        word_t h;
        h = a ^ (a >> 16);
        h = h * 32'h045d_9f3b;
        return h ^ (h >> 16);
    endfunction

    // Bus lanes into core order
    function automatic word_t bus_to_core(input word_t w);
        return BUS_LITTLE ? {w[7:0], w[15:8], w[23:16], w[31:24]} : w;
    endfunction

    function automatic logic in_err_range(input addr_t a);
        return (a >= ERR_BASE) && (a < ERR_BASE + 32'd16);
    endfunction

    task automatic check(input string field, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, field, exp, act);
            $display("Finished with errors");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Offsets are from RESET_PC and offset 0 in trap, redirect or update means none
    task add_row(input int lead, input addr_t trap_off, input addr_t redir_off,
                 input addr_t upd_off, input addr_t upd_tgt, input logic taken,
                 input int stall_n, input addr_t pc_off, input logic mal,
                 input logic fault, input logic pred, input addr_t tgt_off);
        row_t r;
        r.lead         = lead;
        r.trap.valid   = (trap_off != 0);
        r.trap.target  = RESET_PC + trap_off;
        r.redir.valid  = (redir_off != 0);
        r.redir.target = RESET_PC + redir_off;
        r.upd.valid    = (upd_off != 0);
        r.upd.pc       = RESET_PC + upd_off;
        r.upd.target   = RESET_PC + upd_tgt;
        r.upd.taken    = taken;
        r.stall_n      = stall_n;
        r.pc           = RESET_PC + pc_off;
        r.mal          = mal;
        r.fault        = fault;
        r.pred         = pred;
        r.tgt          = RESET_PC + tgt_off;
        rows.push_back(r);
    endtask

    // Samples just after the edge where a new entry shows valid with stall low
    task tick(output logic fresh);
        @(posedge CLK);
        #1;
        fresh = fetch_ex.valid & ~stall;   // Stall still holds its value from this edge
    endtask

    // Wishbone slave with 0 to 3 wait states that answers 1 ns after the edge
    always @(posedge CLK) begin
        #1;
        if (wb_rsp.ack || wb_rsp.err) begin
            wb_rsp = '0;                   // One-cycle response
        end else if (wb_req.cyc) begin
            if (!in_cycle) begin
                check("stb", 1, wb_req.stb);     // STB rises with CYC
                check("we", 0, wb_req.we);       // Fetch never writes
                check("sel", 4'hf, wb_req.sel);
                in_cycle = 1'b1;
                lfsr     = lfsr_next(lfsr);
                waits[0] = lfsr[0];
                lfsr     = lfsr_next(lfsr);
                waits[1] = lfsr[0];
            end
            if (waits == 2'd0) begin
                in_cycle = 1'b0;
                if (in_err_range(wb_req.adr)) begin
                    wb_rsp.err = 1'b1;
                end else begin
                    wb_rsp.ack   = 1'b1;
                    wb_rsp.dat_r = mem[wb_req.adr[11:2]];
                end
            end else begin
                waits = waits - 2'd1;
            end
        end
    end

    initial begin
        row_t  r;
        logic  fresh;
        int    left;
        word_t exp_instr;
        nRST       = 1'b0;
        stall      = 1'b0;
        trap       = '0;
        redirect   = '0;
        btb_update = '0;
        wb_rsp     = '0;
        lfsr       = 32'd89464;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = addr_hash(RESET_PC + 4 * i);
        end
        //      lead trap  redir upd   utgt  tk st pc     mal flt prd tgt
        add_row(0, 'h000, 'h000, 'h000, 'h000, 0, 0, 'h000, 0, 0, 0, 'h000);
        add_row(0, 'h000, 'h000, 'h000, 'h000, 0, 0, 'h004, 0, 0, 0, 'h000);
        add_row(0, 'h000, 'h000, 'h000, 'h000, 0, 5, 'h008, 0, 0, 0, 'h000);
        add_row(0, 'h000, 'h000, 'h000, 'h000, 0, 0, 'h00C, 0, 0, 0, 'h000);
        add_row(0, 'h000, 'h000, 'h000, 'h000, 0, 3, 'h010, 0, 0, 0, 'h000);
        add_row(1, 'h000, 'h200, 'h000, 'h000, 0, 0, 'h200, 0, 0, 0, 'h000);  // Drops 0x14
        add_row(0, 'h000, 'h000, 'h000, 'h000, 0, 0, 'h204, 0, 0, 0, 'h000);
        add_row(1, 'h100, 'h300, 'h000, 'h000, 0, 0, 'h100, 0, 0, 0, 'h000);  // Trap wins
        add_row(0, 'h000, 'h000, 'h108, 'h400, 1, 0, 'h104, 0, 0, 0, 'h000);
        add_row(0, 'h000, 'h000, 'h000, 'h000, 0, 0, 'h108, 0, 0, 1, 'h400);
        add_row(0, 'h000, 'h000, 'h000, 'h000, 0, 0, 'h400, 0, 0, 0, 'h000);
        add_row(0, 'h000, 'h108, 'h108, 'h400, 0, 0, 'h108, 0, 0, 0, 'h000);  // Not taken
        add_row(0, 'h000, 'h000, 'h000, 'h000, 0, 0, 'h10C, 0, 0, 0, 'h000);
        add_row(0, 'h000, 'h502, 'h000, 'h000, 0, 0, 'h502, 1, 0, 0, 'h000);
        add_row(0, 'h000, 'h000, 'h000, 'h000, 0, 0, 'h506, 1, 0, 0, 'h000);
        add_row(0, 'h000, 'h80C, 'h000, 'h000, 0, 0, 'h80C, 0, 1, 0, 'h000);
        add_row(0, 'h000, 'h000, 'h000, 'h000, 0, 4, 'h810, 0, 0, 0, 'h000);
        add_row(0, 'h000, 'h600, 'h000, 'h000, 0, 3, 'h600, 0, 0, 0, 'h000);  // Flush under stall
        add_row(0, 'h000, 'h000, 'h000, 'h000, 0, 0, 'h604, 0, 0, 0, 'h000);

        repeat (2) @(posedge CLK);
        test_name = "reset";
        check("valid", 0, fetch_ex.valid);
        check("cyc", 0, wb_req.cyc);
        #1 nRST = 1'b1;
        tick(fresh);
        check("cyc", 1, wb_req.cyc);       // First edge after reset starts the fetch
        check("adr", RESET_PC, wb_req.adr);

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            test_name = $sformatf("row %0d", i);
            repeat (r.lead) begin
                tick(fresh);
                check("no entry during lead", 0, fresh);
            end
            trap       = r.trap;
            redirect   = r.redir;
            btb_update = r.upd;
            left       = r.stall_n;
            stall      = (left != 0);
            fresh      = 1'b0;
            while (!fresh) begin
                tick(fresh);
                if (trap.valid || redirect.valid) begin
                    check("valid after flush", 0, fetch_ex.valid);
                end
                trap       = '0;                // Pulses last one edge
                redirect   = '0;
                btb_update = '0;
                if (left != 0) begin
                    left--;
                end
                stall = (left != 0);
            end
            exp_instr = (r.mal || r.fault) ? '0 : bus_to_core(mem[r.pc[11:2]]);
            check("pc", r.pc, fetch_ex.pc);
            check("pc4", r.pc + 32'd4, fetch_ex.pc4);
            check("instr", exp_instr, fetch_ex.instr);
            check("mal_insn", r.mal, fetch_ex.mal_insn);
            check("fault_insn", r.fault, fetch_ex.fault_insn);
            check("prediction", r.pred, fetch_ex.prediction);
            if (r.pred) begin
                check("predicted_address", r.tgt, fetch_ex.predicted_address);
            end
            if (r.mal || r.fault) begin
                check("badaddr", r.pc, fetch_ex.badaddr);
            end
        end

        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Per-row budget that covers stalls and wait states
    initial begin
        #1;
        repeat (rows.size() * 40) @(posedge CLK);
        $display("Timeout after %0d cycles, the fetch unit stopped delivering entries",
                 rows.size() * 40);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* verilog/branch_target_buffer.sv */
/*
 * Direct-mapped branch target buffer. Lookup on the fetch PC is
 * combinational; resolved branches from execute write on the edge.
 */
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer #(
    parameter int BTB_ENTRIES = 16   // Power of two
) (
    input  logic                CLK,
    input  logic                nRST,
    input  fetch_pkg::addr_t    lookup_pc,
    input  fetch_pkg::btb_upd_t update,
    output logic                hit_taken,
    output fetch_pkg::addr_t    target
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = 32 - IDX_W - 2;   // Word offset bits are not stored

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    logic [BTB_ENTRIES-1:0] valid_q;         // Only the valid bits see reset
    tag_t                   tag_mem    [BTB_ENTRIES];
    addr_t                  target_mem [BTB_ENTRIES];
    logic                   taken_mem  [BTB_ENTRIES];

    idx_t rd_idx;
    tag_t rd_tag;
    idx_t wr_idx;
    tag_t wr_tag;

    // Lookup side
    assign rd_idx = lookup_pc[IDX_W+1:2];
    assign rd_tag = lookup_pc[31:IDX_W+2];

    // Update side
    assign wr_idx = update.pc[IDX_W+1:2];
    assign wr_tag = update.pc[31:IDX_W+2];

    // Predict taken only on a real tag match with taken set
    assign hit_taken = valid_q[rd_idx] & (tag_mem[rd_idx] == rd_tag) & taken_mem[rd_idx];
    assign target    = target_mem[rd_idx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else if (update.valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Not-taken update overwrites the slot and so drops the prediction
    always_ff @(posedge CLK) begin
        if (update.valid) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= update.target;
            taken_mem[wr_idx]  <= update.taken;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_ex_latch.sv */
/*
 * Fetch-to-execute register. Puts the bus word into core byte order,
 * squashes exceptions to a zero instruction, and holds or flushes the slot.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_ex_latch #(
    parameter bit BUS_LITTLE = 1'b1
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 load,
    input  logic                 flush,
    input  fetch_pkg::word_t     rdata,
    input  logic                 fault,
    input  logic                 mal,
    input  fetch_pkg::addr_t     pc,
    input  fetch_pkg::addr_t     pc4,
    input  fetch_pkg::addr_t     pred_target,
    input  logic                 pred_taken,
    output fetch_pkg::fetch_ex_t entry
);
    import fetch_pkg::*;

    word_t instr_ord;   // Word in core byte order
    logic  bus_fault;   // Bus error that belongs to this slot

    assign instr_ord = BUS_LITTLE ? {rdata[7:0], rdata[15:8], rdata[23:16], rdata[31:24]}
                                  : rdata;

    // A misaligned slot never went to the bus, so any error flag is left over
    assign bus_fault = fault & ~mal;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            entry <= '0;
        end else if (flush) begin
            entry.valid <= 1'b0;                  // Wins over a stall
        end else if (load) begin
            entry.valid             <= 1'b1;      // Exceptions still travel to execute
            entry.instr             <= (mal || bus_fault) ? '0 : instr_ord;
            entry.pc                <= pc;
            entry.pc4               <= pc4;
            entry.mal_insn          <= mal;
            entry.fault_insn        <= bus_fault;
            entry.badaddr           <= pc;
            entry.prediction        <= pred_taken;   // Same edge the PC took it
            entry.predicted_address <= pred_target;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_hazard_ctrl.sv */
/*
 * Fetch control FSM. Starts bus cycles, parks a finished word while the
 * pipeline stalls, discards fetches overtaken by a redirect, and decides
 * on which edges the PC and the fetch-to-execute register move.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_hazard_ctrl (
    input  logic CLK,
    input  logic nRST,
    input  logic trap_valid,
    input  logic redirect_valid,
    input  logic stall,
    input  logic pc_misaligned,
    input  logic bus_done,
    input  logic bus_err,
    output logic pc_en,
    output logic bus_start,
    output logic latch_load,
    output logic latch_flush
);
    import fetch_pkg::*;

    fetch_state_e state;
    fetch_state_e next_state;
    logic         redir;      // Trap or branch redirect sampled this edge
    logic         finished;   // Bus cycle complete, or word still parked
    logic         consume;    // Something goes into the latch on this edge

    assign redir    = trap_valid | redirect_valid;
    assign finished = bus_done | bus_err;   // ERR ends a cycle the same as ACK

    // A misaligned PC never reaches the bus, its exception slot is loaded from IDLE
    assign consume = ~stall & ~redir &
                     (((state == IDLE) & pc_misaligned) |
                      ((state == REQ) & finished));

    // Only one cycle outstanding, and never with an address about to change
    assign bus_start = (state == IDLE) & ~pc_misaligned & ~redir;

    assign pc_en      = consume;   // PC moves exactly when a slot is filled
    assign latch_load = consume;

    // Redirect flushes even under stall
    // An unstalled edge with nothing new inserts a bubble
    assign latch_flush = redir | (~stall & ~consume);

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (bus_start) begin
                    next_state = REQ;
                end
            end
            REQ: begin
                if (redir) begin
                    // Word already back is simply dropped, otherwise wait it out
                    next_state = finished ? IDLE : DRAIN;
                end else if (consume) begin
                    next_state = IDLE;   // Master needs an idle cycle before next CYC
                end
            end
            DRAIN: begin
                if (finished) begin
                    next_state = IDLE;   // Stale data never reaches the latch
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_pc_gen.sv */
/*
 * Program counter with the next-PC priority mux.
 * Trap beats redirect beats BTB prediction beats PC+4.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h8000_0000
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 pc_en,
    input  fetch_pkg::redirect_t trap,
    input  fetch_pkg::redirect_t redirect,
    input  logic                 predict_taken,
    input  fetch_pkg::addr_t     predict_target,
    output fetch_pkg::addr_t     pc,
    output fetch_pkg::addr_t     pc4,
    output logic                 pc_misaligned
);
    import fetch_pkg::*;

    addr_t npc;        // Candidate for the next PC
    logic  force_load; // Redirects ignore pc_en

    assign pc4 = pc + 32'd4;

    // Fixed priority, highest first
    always_comb begin
        if (trap.valid) begin
            npc = trap.target;           // Exception or interrupt vector
        end else if (redirect.valid) begin
            npc = redirect.target;       // Mispredicted branch or jump from execute
        end else if (predict_taken) begin
            npc = predict_target;        // BTB hit on current PC
        end else begin
            npc = pc4;
        end
    end

    assign force_load = trap.valid | redirect.valid;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= RESET_PC;
        end else if (force_load || pc_en) begin
            pc <= npc;
        end
    end

    // No compressed instructions, so the low two bits must be zero
    assign pc_misaligned = |pc[1:0];

endmodule

`default_nettype wire

/* verilog/fetch_pkg.sv */
/*
 * Shared types for the RV32I fetch front end. Every fetch module and the
 * testbench import this package for widths, bus and redirect structs.
 */
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] word_t;   // Instruction or data word
    typedef logic [31:0] addr_t;   // Byte address

    // One slot of the fetch-to-execute pipeline register
    typedef struct packed {
        logic  valid;              // Slot holds a real instruction
        word_t instr;              // Forced to zero when the fetch raised an exception
        addr_t pc;                 // Address the word came from
        addr_t pc4;                // Fall-through address
        logic  mal_insn;           // PC not word aligned
        logic  fault_insn;         // Bus answered with ERR
        addr_t badaddr;            // Faulting address for the trap handler
        logic  prediction;         // BTB steered the PC after this one
        addr_t predicted_address;  // Where the BTB steered it
    } fetch_ex_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;            // Fetch only reads
        logic [3:0] sel;
        addr_t      adr;
        word_t      dat_w;
    } wb_req_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic  ack;
        logic  err;
        word_t dat_r;
    } wb_rsp_t;

    // Trap vector or execute-stage branch redirect
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    // Resolved branch written back into the BTB
    typedef struct packed {
        logic  valid;
        addr_t pc;                 // Branch instruction address
        addr_t target;             // Resolved target
        logic  taken;              // 0 clears the prediction for this slot
    } btb_upd_t;

    // Fetch control states
    typedef enum logic [1:0] {
        IDLE,                      // No bus cycle outstanding
        REQ,                       // Cycle outstanding, or finished word parked under stall
        DRAIN                      // Cycle outstanding whose word gets thrown away
    } fetch_state_e;

endpackage

`default_nettype wire

/* verilog/fetch_unit_top.sv */
/*
 * Fetch front end top level. Wires the control FSM, PC generator, BTB,
 * Wishbone master and fetch-to-execute register together.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_top #(
    parameter fetch_pkg::addr_t RESET_PC    = 32'h8000_0000,
    parameter int               BTB_ENTRIES = 16,
    parameter bit               BUS_LITTLE  = 1'b1
) (
    input  logic                 CLK,
    input  logic                 nRST,
    output fetch_pkg::wb_req_t   wb_req,
    input  fetch_pkg::wb_rsp_t   wb_rsp,
    input  fetch_pkg::redirect_t trap,
    input  fetch_pkg::redirect_t redirect,
    input  fetch_pkg::btb_upd_t  btb_update,
    input  logic                 stall,
    output fetch_pkg::fetch_ex_t fetch_ex
);
    import fetch_pkg::*;

    logic  pc_en;
    logic  bus_start;
    logic  latch_load;
    logic  latch_flush;
    logic  pc_misaligned;
    logic  bus_done;
    logic  bus_err;
    logic  predict_taken;
    addr_t pc;
    addr_t pc4;
    addr_t predict_target;
    word_t rdata;            // Bus byte order

    fetch_hazard_ctrl u_fetch_hazard_ctrl (
        .CLK            (CLK),
        .nRST           (nRST),
        .trap_valid     (trap.valid),
        .redirect_valid (redirect.valid),
        .stall          (stall),
        .pc_misaligned  (pc_misaligned),
        .bus_done       (bus_done),
        .bus_err        (bus_err),
        .pc_en          (pc_en),
        .bus_start      (bus_start),
        .latch_load     (latch_load),
        .latch_flush    (latch_flush)
    );

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_fetch_pc_gen (
        .CLK            (CLK),
        .nRST           (nRST),
        .pc_en          (pc_en),
        .trap           (trap),
        .redirect       (redirect),
        .predict_taken  (predict_taken),
        .predict_target (predict_target),
        .pc             (pc),
        .pc4            (pc4),
        .pc_misaligned  (pc_misaligned)
    );

    branch_target_buffer #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_branch_target_buffer (
        .CLK       (CLK),
        .nRST      (nRST),
        .lookup_pc (pc),
        .update    (btb_update),
        .hit_taken (predict_taken),
        .target    (predict_target)
    );

    fetch_wb_master u_fetch_wb_master (
        .CLK    (CLK),
        .nRST   (nRST),
        .start  (bus_start),
        .addr   (pc),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .rdata  (rdata),
        .done   (bus_done),
        .err    (bus_err)
    );

    fetch_ex_latch #(
        .BUS_LITTLE (BUS_LITTLE)
    ) u_fetch_ex_latch (
        .CLK         (CLK),
        .nRST        (nRST),
        .load        (latch_load),
        .flush       (latch_flush),
        .rdata       (rdata),
        .fault       (bus_err),
        .mal         (pc_misaligned),
        .pc          (pc),
        .pc4         (pc4),
        .pred_target (predict_target),
        .pred_taken  (predict_taken),
        .entry       (fetch_ex)
    );

endmodule

`default_nettype wire

/* verilog/fetch_wb_master.sv */
/*
 * Wishbone classic read master for instruction fetch. One read at a time;
 * the finished word and its error stay parked until the next start.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_wb_master (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               start,
    input  fetch_pkg::addr_t   addr,
    output fetch_pkg::wb_req_t wb_req,
    input  fetch_pkg::wb_rsp_t wb_rsp,
    output fetch_pkg::word_t   rdata,
    output logic               done,
    output logic               err
);
    import fetch_pkg::*;

    logic  busy;      // CYC and STB high
    logic  held;      // Completed word waiting in rdata_q
    logic  finish;    // ACK or ERR seen on this edge
    logic  launch;    // New cycle begins on this edge
    addr_t adr_q;
    word_t rdata_q;
    logic  err_q;

    assign finish = busy & (wb_rsp.ack | wb_rsp.err);
    assign launch = start & ~busy;   // Start while busy is not accepted

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
            held <= 1'b0;
        end else if (finish) begin
            busy <= 1'b0;            // CYC low for at least one cycle after a transfer
            held <= 1'b1;
        end else if (launch) begin
            busy <= 1'b1;
            held <= 1'b0;            // Old word is no longer wanted
        end
    end

    // Address stays put for the whole cycle
    always_ff @(posedge CLK) begin
        if (launch) begin
            adr_q <= addr;
        end
        if (finish) begin
            rdata_q <= wb_rsp.dat_r;
            err_q   <= wb_rsp.err;
        end
    end

    always_comb begin
        wb_req.cyc   = busy;
        wb_req.stb   = busy;
        wb_req.we    = 1'b0;         // Read only
        wb_req.sel   = 4'hf;         // Always a full word
        wb_req.adr   = adr_q;
        wb_req.dat_w = '0;
    end

    // Pass the response straight through on the finishing edge, else the parked copy
    assign rdata = busy ? wb_rsp.dat_r : rdata_q;
    assign done  = busy ? wb_rsp.ack : (held & ~err_q);
    assign err   = busy ? wb_rsp.err : (held & err_q);

endmodule

`default_nettype wire
